/* hw/nbody_pkg.sv */
package nbody_pkg;

  // Lane count, one per axis (x and y)
  localparam int NUM_AXES = 2;

  // Widest body index the address map allows
  localparam int IDX_W = 9;

  typedef logic [31:0] bus_word_t;
  typedef logic [63:0] body_word_t;
  typedef logic [IDX_W-1:0] body_idx_t;

  // ====================
  // Bus function codes, taken from address bits 15..9
  // ====================
  typedef enum logic [6:0] {
    // Registers
    FN_GO       = 7'h40,
    FN_READ     = 7'h41,
    FN_N_BODIES = 7'h42,
    FN_GAP      = 7'h43,
    // Body words, lower half first
    FN_X_LO     = 7'h44,
    FN_X_HI     = 7'h45,
    FN_Y_LO     = 7'h46,
    FN_Y_HI     = 7'h47,
    FN_VX_LO    = 7'h4a,
    FN_VX_HI    = 7'h4b,
    FN_VY_LO    = 7'h4c,
    FN_VY_HI    = 7'h4d,
    // Readback
    FN_DONE     = 7'h50,
    FN_RD_X_LO  = 7'h51,
    FN_RD_X_HI  = 7'h52,
    FN_RD_Y_LO  = 7'h53,
    FN_RD_Y_HI  = 7'h54
  } bus_func_e;

  // Run sequencer states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_STEP,
    ST_DRAIN
  } seq_state_e;

  // ====================
  // Per-lane commands for one cycle
  // ====================
  typedef struct packed {
    body_idx_t  rd_idx;
    logic       step_valid;
    logic       step_last;
    logic       wr_pos;
    logic       wr_vel;
    body_idx_t  wr_idx;
    body_word_t wr_data;
  } lane_ctrl_t;

endpackage

/* hw/readback_mux.sv */
`timescale 1ns/10ps

module readback_mux (
  input  logic                                             clk,
  input  logic                                             rst,
  input  nbody_pkg::bus_func_e                             rd_func_i,
  input  logic                                             rd_en_i,
  input  nbody_pkg::body_word_t [nbody_pkg::NUM_AXES-1:0]  pos_q_i,
  input  logic                                             done_i,
  output nbody_pkg::bus_word_t                             readdata_o
);
  import nbody_pkg::*;

  bus_word_t rd_sel;

  // Lane 0 is x, lane 1 is y
  always_comb begin
    case (rd_func_i)
      FN_DONE:    rd_sel = {31'd0, done_i};
      FN_RD_X_LO: rd_sel = pos_q_i[0][31:0];
      FN_RD_X_HI: rd_sel = pos_q_i[0][63:32];
      FN_RD_Y_LO: rd_sel = pos_q_i[1][31:0];
      FN_RD_Y_HI: rd_sel = pos_q_i[1][63:32];
      default:    rd_sel = '1;
    endcase
  end

  // Holds the last read until the next one lands
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      readdata_o <= '0;
    end else if (rd_en_i) begin
      readdata_o <= rd_sel;
    end
  end

endmodule

/* hw/axis_lane.sv */
`timescale 1ns/10ps

module axis_lane #(
  parameter int BODIES     = 16,
  parameter int ADD_STAGES = 3
) (
  input  logic                   clk,
  input  logic                   rst,
  input  nbody_pkg::lane_ctrl_t  ctrl_i,
  output nbody_pkg::body_word_t  pos_q_o,
  output logic                   wb_last_o
);
  import nbody_pkg::*;

  localparam int AW = $clog2(BODIES);

  body_word_t      pos_mem [BODIES];
  body_word_t      vel_mem [BODIES];
  body_word_t      pos_rd_q;
  body_word_t      vel_rd_q;

  // Stage 0 is the memory read, stages 1..ADD_STAGES carry the sum
  logic [ADD_STAGES:0] s_valid;
  logic [ADD_STAGES:0] s_last;
  body_idx_t           s_idx [ADD_STAGES+1];
  body_word_t          s_sum [1:ADD_STAGES];

  logic            wb_en;
  logic            pos_we;
  logic [AW-1:0]   pos_wr_addr;
  body_word_t      pos_wr_data;

  // ====================
  // Memories
  // ====================
  always_ff @(posedge clk) begin
    pos_rd_q <= pos_mem[ctrl_i.rd_idx[AW-1:0]];
    vel_rd_q <= vel_mem[ctrl_i.rd_idx[AW-1:0]];
    if (pos_we) begin
      pos_mem[pos_wr_addr] <= pos_wr_data;
    end
    // Velocity only changes from software
    if (ctrl_i.wr_vel) begin
      vel_mem[ctrl_i.wr_idx[AW-1:0]] <= ctrl_i.wr_data;
    end
  end

  assign pos_q_o = pos_rd_q;

  // ====================
  // Adder pipeline
  // ====================
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s_valid <= '0;
      s_last  <= '0;
    end else begin
      s_valid <= {s_valid[ADD_STAGES-1:0], ctrl_i.step_valid};
      s_last  <= {s_last[ADD_STAGES-1:0], ctrl_i.step_valid & ctrl_i.step_last};
    end
  end

  always_ff @(posedge clk) begin
    s_idx[0] <= ctrl_i.rd_idx;
    s_idx[1] <= s_idx[0];
    // Wrapping fixed-point add
    s_sum[1] <= pos_rd_q + vel_rd_q;
    for (int i = 2; i <= ADD_STAGES; i++) begin
      s_idx[i] <= s_idx[i-1];
      s_sum[i] <= s_sum[i-1];
    end
  end

  // Writeback wins the position port
  assign wb_en       = s_valid[ADD_STAGES];
  assign pos_we      = wb_en | ctrl_i.wr_pos;
  assign pos_wr_addr = wb_en ? s_idx[ADD_STAGES][AW-1:0] : ctrl_i.wr_idx[AW-1:0];
  assign pos_wr_data = wb_en ? s_sum[ADD_STAGES] : ctrl_i.wr_data;
  assign wb_last_o   = s_last[ADD_STAGES];

  a_no_wr_during_wb: assert property (@(posedge clk) disable iff (rst)
    !(wb_en && ctrl_i.wr_pos));

endmodule

/* hw/step_sequencer.sv */
`timescale 1ns/10ps

module step_sequencer #(
  parameter int BODIES = 16
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          go_i,
  input  logic                          read_i,
  input  logic [$clog2(BODIES + 1)-1:0] n_bodies_i,
  input  nbody_pkg::bus_word_t          gap_i,
  input  logic                          step_done_i,
  output logic                          step_valid_o,
  output nbody_pkg::body_idx_t          step_idx_o,
  output logic                          step_last_o,
  output logic                          idle_o,
  output logic                          done_o
);
  import nbody_pkg::*;

  localparam int CNT_W = $clog2(BODIES + 1);

  seq_state_e       state_q;
  logic [CNT_W-1:0] idx_q;
  logic [CNT_W-1:0] idx_next;
  bus_word_t        step_cnt_q;
  logic             done_q;

  assign idx_next     = idx_q + 1'b1;
  assign step_valid_o = (state_q == ST_STEP);
  assign step_idx_o   = body_idx_t'(idx_q);
  assign step_last_o  = step_valid_o && (idx_next == n_bodies_i);
  assign idle_o       = (state_q == ST_IDLE);
  assign done_o       = done_q;

  // ====================
  // Run FSM
  // ====================
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q    <= ST_IDLE;
      idx_q      <= '0;
      step_cnt_q <= '0;
      done_q     <= 1'b0;
    end else if (!go_i) begin
      // Abort, and a dropped go also clears done
      state_q <= ST_IDLE;
      done_q  <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (read_i) begin
            done_q <= 1'b0;
          end else if (!done_q) begin
            idx_q      <= '0;
            step_cnt_q <= '0;
            // Nothing to integrate, finish at once
            if (n_bodies_i == '0) begin
              done_q <= 1'b1;
            end else begin
              state_q <= ST_STEP;
            end
          end
        end
        ST_STEP: begin
          // One body issued per cycle
          idx_q <= idx_next;
          if (step_last_o) begin
            state_q <= ST_DRAIN;
          end
        end
        ST_DRAIN: begin
          // Wait for the last writeback before the next step reads
          if (step_done_i) begin
            idx_q <= '0;
            if ((step_cnt_q + 32'd1) >= gap_i) begin
              done_q  <= 1'b1;
              state_q <= ST_IDLE;
            end else begin
              step_cnt_q <= step_cnt_q + 32'd1;
              state_q    <= ST_STEP;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  a_done_in_idle: assert property (@(posedge clk) disable iff (rst)
    done_q |-> (state_q == ST_IDLE));

  a_idx_in_range: assert property (@(posedge clk) disable iff (rst)
    step_valid_o |-> (idx_q < n_bodies_i));

  // A run starts only with go high, read low and done clear
  a_start_needs_go: assert property (@(posedge clk) disable iff (rst)
    (state_q == ST_IDLE && (!go_i || read_i || done_q)) |=> (state_q == ST_IDLE));

endmodule

/* hw/host_regs.sv */
`timescale 1ns/10ps

module host_regs #(
  parameter int BODIES = 16
) (
  input  logic                                            clk,
  input  logic                                            rst,
  input  logic                                            chipselect_i,
  input  logic                                            write_i,
  input  logic                                            read_i,
  input  logic [15:0]                                     addr_i,
  input  nbody_pkg::bus_word_t                            writedata_i,
  input  logic [nbody_pkg::NUM_AXES-1:0]                  wb_last_i,
  output nbody_pkg::lane_ctrl_t [nbody_pkg::NUM_AXES-1:0] lane_ctrl_o,
  output logic                                            done_o,
  output nbody_pkg::bus_func_e                            rd_func_o,
  output logic                                            rd_en_o
);
  import nbody_pkg::*;

  localparam int CNT_W = $clog2(BODIES + 1);

  // Upper-half codes that commit a word, per lane
  localparam bus_func_e POS_HI_FN [NUM_AXES] = '{FN_X_HI, FN_Y_HI};
  localparam bus_func_e VEL_HI_FN [NUM_AXES] = '{FN_VX_HI, FN_VY_HI};

  bus_func_e        func;
  logic             wr_acc;
  logic             cfg_wr;
  logic             body_lo;
  logic             go_q;
  logic             read_q;
  logic [CNT_W-1:0] n_bodies_q;
  bus_word_t        gap_q;
  bus_word_t        lo_q;
  logic             seq_valid;
  logic             seq_last;
  logic             seq_idle;
  body_idx_t        seq_idx;

  assign func    = bus_func_e'(addr_i[15:9]);
  assign wr_acc  = chipselect_i & write_i;
  // Body and config writes only land while the engine is idle
  assign cfg_wr  = wr_acc & seq_idle;
  assign body_lo = func inside {FN_X_LO, FN_Y_LO, FN_VX_LO, FN_VY_LO};

  // ====================
  // Configuration registers
  // ====================
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      go_q       <= 1'b0;
      read_q     <= 1'b0;
      n_bodies_q <= '0;
      gap_q      <= '0;
      rd_en_o    <= 1'b0;
      rd_func_o  <= FN_DONE;
    end else begin
      // Align the read code with the synchronous memory read
      rd_en_o   <= chipselect_i & read_i;
      rd_func_o <= func;
      if (wr_acc) begin
        case (func)
          FN_GO:       go_q <= writedata_i[0];
          FN_READ:     read_q <= writedata_i[0];
          FN_N_BODIES: if (seq_idle) n_bodies_q <= writedata_i[CNT_W-1:0];
          FN_GAP:      if (seq_idle) gap_q <= writedata_i;
          default:     ;
        endcase
      end
    end
  end

  // Lower half waits here for its upper half
  always_ff @(posedge clk) begin
    if (wr_acc && body_lo) begin
      lo_q <= writedata_i;
    end
  end

  step_sequencer #(
    .BODIES (BODIES)
  ) step_sequencer_i (
    .clk          (clk),
    .rst          (rst),
    .go_i         (go_q),
    .read_i       (read_q),
    .n_bodies_i   (n_bodies_q),
    .gap_i        (gap_q),
    .step_done_i  (wb_last_i[0]),
    .step_valid_o (seq_valid),
    .step_idx_o   (seq_idx),
    .step_last_o  (seq_last),
    .idle_o       (seq_idle),
    .done_o       (done_o)
  );

  // ====================
  // Lane control words
  // ====================
  always_comb begin
    for (int a = 0; a < NUM_AXES; a++) begin
      // Sequencer owns the read port during a step
      lane_ctrl_o[a].rd_idx     = seq_valid ? seq_idx : addr_i[IDX_W-1:0];
      lane_ctrl_o[a].step_valid = seq_valid;
      lane_ctrl_o[a].step_last  = seq_last;
      lane_ctrl_o[a].wr_pos     = cfg_wr && (func == POS_HI_FN[a]);
      lane_ctrl_o[a].wr_vel     = cfg_wr && (func == VEL_HI_FN[a]);
      lane_ctrl_o[a].wr_idx     = addr_i[IDX_W-1:0];
      lane_ctrl_o[a].wr_data    = {writedata_i, lo_q};
    end
  end

  // Lanes run in lockstep, so lane 0 speaks for all of them
  a_lanes_lockstep: assert property (@(posedge clk) disable iff (rst)
    (|wb_last_i) |-> (&wb_last_i));

endmodule

/* hw/nbody_top.sv */
`timescale 1ns/10ps

module nbody_top #(
  parameter int BODIES     = 16,
  parameter int ADD_STAGES = 3
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 chipselect_i,
  input  logic                 write_i,
  input  logic                 read_i,
  input  logic [15:0]          addr_i,
  input  nbody_pkg::bus_word_t writedata_i,
  output nbody_pkg::bus_word_t readdata_o
);
  import nbody_pkg::*;

  lane_ctrl_t [NUM_AXES-1:0] lane_ctrl;
  body_word_t [NUM_AXES-1:0] pos_q;
  logic       [NUM_AXES-1:0] wb_last;
  logic                      done;
  bus_func_e                 rd_func;
  logic                      rd_en;

  host_regs #(
    .BODIES (BODIES)
  ) host_regs_i (
    .clk          (clk),
    .rst          (rst),
    .chipselect_i (chipselect_i),
    .write_i      (write_i),
    .read_i       (read_i),
    .addr_i       (addr_i),
    .writedata_i  (writedata_i),
    .wb_last_i    (wb_last),
    .lane_ctrl_o  (lane_ctrl),
    .done_o       (done),
    .rd_func_o    (rd_func),
    .rd_en_o      (rd_en)
  );

  // ====================
  // One lane per axis
  // ====================
  for (genvar g = 0; g < NUM_AXES; g++) begin : g_lane
    axis_lane #(
      .BODIES     (BODIES),
      .ADD_STAGES (ADD_STAGES)
    ) axis_lane_i (
      .clk       (clk),
      .rst       (rst),
      .ctrl_i    (lane_ctrl[g]),
      .pos_q_o   (pos_q[g]),
      .wb_last_o (wb_last[g])
    );
  end

  readback_mux readback_mux_i (
    .clk        (clk),
    .rst        (rst),
    .rd_func_i  (rd_func),
    .rd_en_i    (rd_en),
    .pos_q_i    (pos_q),
    .done_i     (done),
    .readdata_o (readdata_o)
  );

endmodule

/* testbench/tb_nbody.sv */
`timescale 1ns/10ps

module tb_nbody;
  import nbody_pkg::*;

  localparam int BODIES     = 16;
  localparam int ADD_STAGES = 3;
  localparam int NUM_RUNS   = 6;

  typedef struct packed {
    logic [9:0]  n_bodies;
    logic [31:0] gap;
    logic        reread;
  } run_row_t;

  // Each row is loaded, run, then optionally restarted through the READ handshake
  run_row_t runs [NUM_RUNS] = '{
    '{n_bodies: 10'd1,  gap: 32'd1, reread: 1'b0},
    '{n_bodies: 10'd16, gap: 32'd1, reread: 1'b0},
    '{n_bodies: 10'd5,  gap: 32'd3, reread: 1'b1},
    '{n_bodies: 10'd16, gap: 32'd4, reread: 1'b1},
    '{n_bodies: 10'd1,  gap: 32'd7, reread: 1'b0},
    '{n_bodies: 10'd9,  gap: 32'd2, reread: 1'b0}
  };

  logic        clk;
  logic        rst;
  logic        chipselect;
  logic        write;
  logic        read;
  logic [15:0] addr;
  bus_word_t   writedata;
  bus_word_t   readdata;

  integer      seed = 2;
  body_word_t  ref_pos [NUM_AXES][BODIES];
  body_word_t  ref_vel [NUM_AXES][BODIES];

  nbody_top #(
    .BODIES     (BODIES),
    .ADD_STAGES (ADD_STAGES)
  ) nbody_top_i (
    .clk          (clk),
    .rst          (rst),
    .chipselect_i (chipselect),
    .write_i      (write),
    .read_i       (read),
    .addr_i       (addr),
    .writedata_i  (writedata),
    .readdata_o   (readdata)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // ====================
  // Checks
  // ====================
  task automatic check_word(input string what, input int idx, input body_word_t got,
                            input body_word_t exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s of body %0d is %h, expected %h", $time, what, idx, got, exp);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic check_bus(input string what, input bus_word_t got, input bus_word_t exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  // ====================
  // Bus model
  // ====================
  // Tasks start and end 1 ns after a rising edge
  task automatic bus_write(input bus_func_e func, input int idx, input bus_word_t data);
    chipselect = 1'b1;
    write      = 1'b1;
    addr       = {func, idx[8:0]};
    writedata  = data;
    @(posedge clk);
    #1;
    chipselect = 1'b0;
    write      = 1'b0;
  endtask

  // Result lands two edges after the strobe
  task automatic bus_read(input bus_func_e func, input int idx, output bus_word_t data);
    chipselect = 1'b1;
    read       = 1'b1;
    addr       = {func, idx[8:0]};
    @(posedge clk);
    #1;
    chipselect = 1'b0;
    read       = 1'b0;
    @(posedge clk);
    #1;
    data = readdata;
  endtask

  task automatic load_word(input bus_func_e lo_fn, input bus_func_e hi_fn, input int idx,
                           input body_word_t value);
    bus_write(lo_fn, idx, value[31:0]);
    bus_write(hi_fn, idx, value[63:32]);
  endtask

  task automatic read_word(input bus_func_e lo_fn, input bus_func_e hi_fn, input int idx,
                           output body_word_t value);
    bus_word_t lo;
    bus_word_t hi;
    bus_read(lo_fn, idx, lo);
    bus_read(hi_fn, idx, hi);
    value = {hi, lo};
  endtask

  // ====================
  // Reference model
  // ====================
  function automatic body_word_t rand_word();
    bus_word_t hi;
    bus_word_t lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi, lo};
  endfunction

  task automatic load_bodies(input int n);
    for (int i = 0; i < n; i++) begin
      for (int a = 0; a < NUM_AXES; a++) begin
        ref_pos[a][i] = rand_word();
        ref_vel[a][i] = rand_word();
      end
      load_word(FN_X_LO, FN_X_HI, i, ref_pos[0][i]);
      load_word(FN_Y_LO, FN_Y_HI, i, ref_pos[1][i]);
      load_word(FN_VX_LO, FN_VX_HI, i, ref_vel[0][i]);
      load_word(FN_VY_LO, FN_VY_HI, i, ref_vel[1][i]);
    end
  endtask

  // Each step adds the velocity once, wrapping at 64 bits
  task automatic advance_ref(input int n, input bus_word_t gap);
    for (int i = 0; i < n; i++) begin
      for (int a = 0; a < NUM_AXES; a++) begin
        ref_pos[a][i] = ref_pos[a][i] + 64'(gap) * ref_vel[a][i];
      end
    end
  endtask

  task automatic check_positions(input int n, input string when);
    body_word_t got;
    for (int i = 0; i < n; i++) begin
      read_word(FN_RD_X_LO, FN_RD_X_HI, i, got);
      check_word({when, " x"}, i, got, ref_pos[0][i]);
      read_word(FN_RD_Y_LO, FN_RD_Y_HI, i, got);
      check_word({when, " y"}, i, got, ref_pos[1][i]);
    end
  endtask

  task automatic wait_done();
    bus_word_t flag;
    flag = '0;
    while (flag[0] !== 1'b1) begin
      bus_read(FN_DONE, 0, flag);
    end
    check_bus("done flag", flag, 32'd1);
  endtask

  // ====================
  // Watchdog
  // ====================
  function automatic longint run_budget_ns();
    longint total;
    longint n_l;
    longint gap_l;
    longint passes;
    total = 20000;
    for (int r = 0; r < NUM_RUNS; r++) begin
      n_l    = longint'(runs[r].n_bodies);
      gap_l  = longint'(runs[r].gap);
      passes = 1;
      if (runs[r].reread) passes = 2;
      total = total + gap_l * passes * (n_l + longint'(ADD_STAGES) + 10) * 10;
      // Bus traffic for loading and reading back every body
      total = total + n_l * 800;
    end
    return total;
  endfunction

  initial begin
    #(run_budget_ns());
    $display("Timeout: the engine never finished the table of runs");
    $display("*** FAILED ***");
    $fatal(1);
  end

  // ====================
  // Main sequence
  // ====================
  initial begin
    bus_word_t data;
    int        n;
    chipselect = 1'b0;
    write      = 1'b0;
    read       = 1'b0;
    addr       = '0;
    writedata  = '0;
    rst        = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    check_bus("readdata after reset", readdata, '0);
    bus_read(FN_DONE, 0, data);
    check_bus("done after reset", data, 32'd0);
    bus_read(bus_func_e'(7'h7f), 0, data);
    check_bus("unknown code read", data, 32'hffff_ffff);

    for (int r = 0; r < NUM_RUNS; r++) begin
      n = int'(runs[r].n_bodies);
      // Drop go so the engine is idle and done is clear
      bus_write(FN_GO, 0, 32'd0);
      bus_write(FN_READ, 0, 32'd0);
      bus_write(FN_N_BODIES, 0, 32'(n));
      bus_write(FN_GAP, 0, runs[r].gap);
      load_bodies(n);
      check_positions(n, "loaded");

      bus_write(FN_GO, 0, 32'd1);
      wait_done();
      advance_ref(n, runs[r].gap);
      check_positions(n, "after run");

      if (runs[r].reread) begin
        bus_write(FN_READ, 0, 32'd1);
        bus_read(FN_DONE, 0, data);
        check_bus("done after READ=1", data, 32'd0);
        check_positions(n, "after done cleared");
        // Go is still high, so releasing READ starts the next run
        bus_write(FN_READ, 0, 32'd0);
        wait_done();
        advance_ref(n, runs[r].gap);
        check_positions(n, "after second run");
      end
    end

    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* src.f */
hw/nbody_pkg.sv
hw/readback_mux.sv
hw/axis_lane.sv
hw/step_sequencer.sv
hw/host_regs.sv
hw/nbody_top.sv
testbench/tb_nbody.sv

/* Makefile */
VERILATOR ?= verilator
BUILD_DIR ?= build
TOP       ?= tb_nbody
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0
PASS_MSG  := *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
